//--- source/mxv_pkg.sv
`default_nettype none

package mxv_pkg;

	localparam int N_MAX = 8; // largest matrix order
	localparam int ELEM_W = 8;
	localparam int RESULT_W = 19; // holds 8 * 255 * 255
	localparam int MAT_DEPTH = N_MAX * N_MAX;

	typedef logic [ELEM_W-1:0] elem_t;
	typedef logic [RESULT_W-1:0] result_t;

	// n runs 1..8, zero never committed
	typedef logic [$clog2(N_MAX):0] order_t;

	typedef logic [$clog2(MAT_DEPTH)-1:0] mat_idx_t; // row * n + col
	typedef logic [$clog2(N_MAX)-1:0] vec_idx_t;

endpackage

`default_nettype wire

//--- source/frame_pkg.sv
`default_nettype none

package frame_pkg;

	typedef logic [7:0] char_t;

	localparam char_t CHAR_SEP = 8'h5F; // underscore
	localparam char_t CHAR_0 = 8'h30;
	localparam char_t CHAR_9 = 8'h39;
	localparam char_t CHAR_A = 8'h41;
	localparam char_t CHAR_F = 8'h46; // upper case only

	localparam logic [7:0] TOK_FE = 8'hFE; // frame start
	localparam logic [7:0] TOK_EF = 8'hEF; // frame end

	localparam logic [7:0] CMD_SIZE = 8'h01;
	localparam logic [7:0] CMD_LOAD = 8'h02;
	localparam logic [7:0] CMD_START = 8'h03;

	localparam int LEN_MAX = 64; // a full 8x8 matrix

	// SEP_* states expect an underscore, the rest a byte token
	typedef enum logic [3:0] {
		HUNT,
		SEP_LEN,
		LEN,
		SEP_CMD,
		CMD,
		SEP_HDR,
		SIZE_VAL,
		SEP_SIZE,
		DATA,
		SEP_DATA,
		TRAILER
	} parse_state_t;

endpackage

`default_nettype wire

//--- source/token_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module token_assembler (
	input wire logic clk,
	input wire logic rst,
	input wire logic rcv,
	input wire frame_pkg::char_t char,
	output logic tok_valid,
	output mxv_pkg::elem_t tok,
	output logic sep_valid,
	output logic bad_char
);

	logic is_digit;
	logic is_alpha;
	logic is_sep;
	logic [3:0] nib;
	logic [3:0] hi_nib; // first digit of a pair
	logic have_hi;

	assign is_digit = (char >= frame_pkg::CHAR_0) && (char <= frame_pkg::CHAR_9);
	assign is_alpha = (char >= frame_pkg::CHAR_A) && (char <= frame_pkg::CHAR_F);
	assign is_sep = (char == frame_pkg::CHAR_SEP);
	assign nib = is_alpha ? char[3:0] + 4'd9 : char[3:0]; // 'A' is 0x41

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			have_hi <= 1'b0;
			tok_valid <= 1'b0;
			sep_valid <= 1'b0;
			bad_char <= 1'b0;
		end else begin
			tok_valid <= rcv && (is_digit || is_alpha) && have_hi;
			sep_valid <= rcv && is_sep && !have_hi;
			// junk character, or an underscore splitting a pair
			bad_char <= rcv && ((!is_digit && !is_alpha && !is_sep) || (is_sep && have_hi));
			if (rcv) begin
				have_hi <= (is_digit || is_alpha) && !have_hi;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rcv && (is_digit || is_alpha)) begin
			if (have_hi) begin
				tok <= {hi_nib, nib};
			end else begin
				hi_nib <= nib;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/frame_parser.sv
`timescale 1ns/1ps
`default_nettype none

module frame_parser (
	input wire logic clk,
	input wire logic rst,
	input wire logic tok_valid,
	input wire mxv_pkg::elem_t tok,
	input wire logic sep_valid,
	input wire logic bad_char,
	input wire logic busy,
	output mxv_pkg::order_t n,
	output logic mat_we,
	output mxv_pkg::mat_idx_t mat_waddr,
	output logic vec_we,
	output mxv_pkg::vec_idx_t vec_waddr,
	output mxv_pkg::elem_t wdata,
	output logic start,
	output logic frame_ok,
	output logic frame_error
);

	frame_pkg::parse_state_t state;
	frame_pkg::parse_state_t state_nxt;
	logic [6:0] frame_len; // 1..64
	logic [7:0] cmd;
	logic [6:0] cnt; // payload tokens so far
	logic [6:0] nn;
	mxv_pkg::order_t size_val; // held until the trailer
	logic to_mat;
	logic want_tok;
	logic err;
	logic done;
	logic data_we;

	assign nn = n * n;
	assign want_tok = state inside {frame_pkg::LEN, frame_pkg::CMD, frame_pkg::SIZE_VAL,
		frame_pkg::DATA, frame_pkg::TRAILER};

	always_comb begin
		state_nxt = state;
		err = 1'b0;
		done = 1'b0;
		data_we = 1'b0;
		if (state != frame_pkg::HUNT &&
				(bad_char || (tok_valid && !want_tok) || (sep_valid && want_tok))) begin
			err = 1'b1; // grammar broken
		end else begin
			case (state)
				frame_pkg::HUNT: begin
					if (tok_valid && tok == frame_pkg::TOK_FE) state_nxt = frame_pkg::SEP_LEN;
				end
				frame_pkg::SEP_LEN: begin
					if (sep_valid) state_nxt = frame_pkg::LEN;
				end
				frame_pkg::LEN: begin
					if (tok_valid) begin
						if (tok == '0 || tok > frame_pkg::LEN_MAX) err = 1'b1;
						else state_nxt = frame_pkg::SEP_CMD;
					end
				end
				frame_pkg::SEP_CMD: begin
					if (sep_valid) state_nxt = frame_pkg::CMD;
				end
				frame_pkg::CMD: begin
					if (tok_valid) begin
						if (busy) err = 1'b1; // engine still running
						else if (tok inside {frame_pkg::CMD_SIZE, frame_pkg::CMD_LOAD,
								frame_pkg::CMD_START}) state_nxt = frame_pkg::SEP_HDR;
						else err = 1'b1;
					end
				end
				frame_pkg::SEP_HDR: begin
					if (sep_valid) begin
						if (cmd == frame_pkg::CMD_SIZE) state_nxt = frame_pkg::SIZE_VAL;
						else if (cmd == frame_pkg::CMD_START) state_nxt = frame_pkg::TRAILER;
						else if (frame_len == nn || frame_len == {3'b000, n})
							state_nxt = frame_pkg::DATA;
						else err = 1'b1; // load length fits neither store
					end
				end
				frame_pkg::SIZE_VAL: begin
					if (tok_valid) begin
						if (tok == '0 || tok > mxv_pkg::N_MAX) err = 1'b1;
						else state_nxt = frame_pkg::SEP_SIZE;
					end
				end
				frame_pkg::SEP_SIZE: begin
					if (sep_valid) state_nxt = frame_pkg::TRAILER;
				end
				frame_pkg::DATA: begin
					if (tok_valid) begin
						data_we = 1'b1;
						state_nxt = frame_pkg::SEP_DATA;
					end
				end
				frame_pkg::SEP_DATA: begin
					if (sep_valid) begin
						state_nxt = (cnt == frame_len) ? frame_pkg::TRAILER : frame_pkg::DATA;
					end
				end
				frame_pkg::TRAILER: begin
					if (tok_valid) begin
						if (tok == frame_pkg::TOK_EF) begin
							done = 1'b1;
							state_nxt = frame_pkg::HUNT;
						end else begin
							err = 1'b1;
						end
					end
				end
				default: state_nxt = frame_pkg::HUNT;
			endcase
		end
		if (err) state_nxt = frame_pkg::HUNT;
	end

	// payload steering, written on the next edge
	assign mat_we = data_we && to_mat;
	assign vec_we = data_we && !to_mat;
	assign mat_waddr = cnt[5:0];
	assign vec_waddr = cnt[2:0];
	assign wdata = tok;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= frame_pkg::HUNT;
			n <= mxv_pkg::order_t'(mxv_pkg::N_MAX);
			frame_len <= '0;
			cmd <= '0;
			cnt <= '0;
			size_val <= '0;
			to_mat <= 1'b0;
			start <= 1'b0;
			frame_ok <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			state <= state_nxt;
			frame_ok <= done;
			frame_error <= err;
			start <= done && cmd == frame_pkg::CMD_START;
			if (done && cmd == frame_pkg::CMD_SIZE) n <= size_val; // commit on trailer
			if (state == frame_pkg::LEN && state_nxt == frame_pkg::SEP_CMD) frame_len <= tok[6:0];
			if (state == frame_pkg::CMD && state_nxt == frame_pkg::SEP_HDR) cmd <= tok;
			if (state == frame_pkg::SIZE_VAL && state_nxt == frame_pkg::SEP_SIZE)
				size_val <= tok[3:0];
			if (state == frame_pkg::SEP_HDR && state_nxt == frame_pkg::DATA) begin
				to_mat <= (frame_len == nn); // matrix wins when n is 1
				cnt <= '0;
			end
			if (data_we) cnt <= cnt + 7'd1;
		end
	end

endmodule

`default_nettype wire

//--- source/operand_store.sv
`timescale 1ns/1ps
`default_nettype none

module operand_store #(
	parameter int DEPTH = mxv_pkg::N_MAX
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic we,
	input wire logic [$clog2(DEPTH)-1:0] waddr,
	input wire mxv_pkg::elem_t wdata,
	input wire logic [$clog2(DEPTH)-1:0] raddr,
	output mxv_pkg::elem_t rdata
);

	mxv_pkg::elem_t mem [DEPTH];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

	assign rdata = mem[raddr]; // async read for the engine

endmodule

`default_nettype wire

//--- source/mxv_engine.sv
`timescale 1ns/1ps
`default_nettype none

module mxv_engine (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire mxv_pkg::order_t n,
	output mxv_pkg::mat_idx_t mat_raddr,
	input wire mxv_pkg::elem_t mat_rdata,
	output mxv_pkg::vec_idx_t vec_raddr,
	input wire mxv_pkg::elem_t vec_rdata,
	input wire logic full,
	output logic push,
	output mxv_pkg::result_t push_data,
	output logic busy
);

	mxv_pkg::vec_idx_t row;
	mxv_pkg::vec_idx_t col;
	mxv_pkg::result_t acc;
	logic [2*mxv_pkg::ELEM_W-1:0] prod;
	logic pending; // row sum waiting for queue space
	logic last_col;
	logic last_row;

	assign mat_raddr = {3'b000, row} * {2'b00, n} + {3'b000, col};
	assign vec_raddr = col;
	assign prod = mat_rdata * vec_rdata;

	assign last_col = {1'b0, col} == n - 4'd1;
	assign last_row = {1'b0, row} == n - 4'd1;

	assign push = pending && !full;
	assign push_data = acc;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= 1'b0;
			pending <= 1'b0;
			row <= '0;
			col <= '0;
		end else if (!busy) begin
			if (start) begin
				busy <= 1'b1;
				pending <= 1'b0;
				row <= '0;
				col <= '0;
			end
		end else if (pending) begin
			if (push) begin
				if (last_row) busy <= 1'b0; // nth result gone
				else row <= row + 3'd1;
				col <= '0;
				pending <= 1'b0;
			end
		end else begin
			if (last_col) pending <= 1'b1;
			else col <= col + 3'd1;
		end
	end

	// one multiply-accumulate per cycle while a row is open
	always_ff @(posedge clk) begin
		if (!busy || push) begin
			acc <= '0;
		end else if (!pending) begin
			acc <= acc + {{(mxv_pkg::RESULT_W-2*mxv_pkg::ELEM_W){1'b0}}, prod};
		end
	end

endmodule

`default_nettype wire

//--- source/result_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module result_fifo (
	input wire logic clk,
	input wire logic rst,
	input wire logic push,
	input wire mxv_pkg::result_t push_data,
	output logic full,
	output logic result_valid,
	input wire logic result_ready,
	output mxv_pkg::result_t result_data
);

	mxv_pkg::result_t mem [mxv_pkg::N_MAX];
	logic [$clog2(mxv_pkg::N_MAX)-1:0] wr_ptr; // wraps at depth
	logic [$clog2(mxv_pkg::N_MAX)-1:0] rd_ptr;
	logic [$clog2(mxv_pkg::N_MAX):0] count;
	logic wr_en;
	logic rd_en;

	assign full = count == mxv_pkg::N_MAX;
	assign result_valid = count != '0;
	assign result_data = mem[rd_ptr]; // oldest entry
	assign wr_en = push && !full;
	assign rd_en = result_valid && result_ready;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) wr_ptr <= wr_ptr + 1'b1;
			if (rd_en) rd_ptr <= rd_ptr + 1'b1;
			if (wr_en && !rd_en) count <= count + 1'b1;
			else if (rd_en && !wr_en) count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) mem[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

//--- source/mxv_top.sv
`timescale 1ns/1ps
`default_nettype none

module mxv_top (
	input wire logic clk,
	input wire logic rst,
	input wire logic rcv,
	input wire frame_pkg::char_t char,
	output logic frame_ok,
	output logic frame_error,
	output logic busy,
	output logic result_valid,
	input wire logic result_ready,
	output mxv_pkg::result_t result_data
);

	logic tok_valid;
	mxv_pkg::elem_t tok;
	logic sep_valid;
	logic bad_char;
	mxv_pkg::order_t n;
	logic mat_we;
	mxv_pkg::mat_idx_t mat_waddr;
	logic vec_we;
	mxv_pkg::vec_idx_t vec_waddr;
	mxv_pkg::elem_t wdata;
	logic start;
	mxv_pkg::mat_idx_t mat_raddr;
	mxv_pkg::elem_t mat_rdata;
	mxv_pkg::vec_idx_t vec_raddr;
	mxv_pkg::elem_t vec_rdata;
	logic full;
	logic push;
	mxv_pkg::result_t push_data;

	token_assembler u_token_assembler (
		.clk(clk), .rst(rst), .rcv(rcv), .char(char),
		.tok_valid(tok_valid), .tok(tok), .sep_valid(sep_valid), .bad_char(bad_char)
	);

	frame_parser u_frame_parser (
		.clk(clk), .rst(rst), .tok_valid(tok_valid), .tok(tok), .sep_valid(sep_valid),
		.bad_char(bad_char), .busy(busy), .n(n),
		.mat_we(mat_we), .mat_waddr(mat_waddr), .vec_we(vec_we), .vec_waddr(vec_waddr),
		.wdata(wdata), .start(start), .frame_ok(frame_ok), .frame_error(frame_error)
	);

	operand_store #(.DEPTH(mxv_pkg::MAT_DEPTH)) matrix_store (
		.clk(clk), .rst(rst), .we(mat_we), .waddr(mat_waddr), .wdata(wdata),
		.raddr(mat_raddr), .rdata(mat_rdata)
	);

	operand_store #(.DEPTH(mxv_pkg::N_MAX)) vector_store (
		.clk(clk), .rst(rst), .we(vec_we), .waddr(vec_waddr), .wdata(wdata),
		.raddr(vec_raddr), .rdata(vec_rdata)
	);

	mxv_engine u_mxv_engine (
		.clk(clk), .rst(rst), .start(start), .n(n),
		.mat_raddr(mat_raddr), .mat_rdata(mat_rdata),
		.vec_raddr(vec_raddr), .vec_rdata(vec_rdata),
		.full(full), .push(push), .push_data(push_data), .busy(busy)
	);

	result_fifo u_result_fifo (
		.clk(clk), .rst(rst), .push(push), .push_data(push_data), .full(full),
		.result_valid(result_valid), .result_ready(result_ready), .result_data(result_data)
	);

endmodule

`default_nettype wire

//--- verification/mxv_model.svh
`ifndef MXV_MODEL_SVH
`define MXV_MODEL_SVH

`default_nettype none

typedef logic [7:0] byte_q_t [$];

// shadow state, follows the frame commit rules
int unsigned m_n;
mxv_pkg::elem_t m_mat [mxv_pkg::MAT_DEPTH];
mxv_pkg::elem_t m_vec [mxv_pkg::N_MAX];
mxv_pkg::result_t expected_q [$]; // row order

function automatic void model_reset();
	m_n = mxv_pkg::N_MAX; // order after reset
	foreach (m_mat[i]) m_mat[i] = '0;
	foreach (m_vec[i]) m_vec[i] = '0;
	expected_q.delete();
endfunction

function automatic string hex_byte(input logic [7:0] b);
	string s;
	s = $sformatf("%02h", b);
	return s.toupper(); // only upper case digits are legal
endfunction

function automatic string build_frame(input logic [7:0] len, input logic [7:0] cmd,
		input byte_q_t payload, input logic [7:0] trailer);
	string s;
	s = {"FE_", hex_byte(len), "_", hex_byte(cmd), "_"};
	foreach (payload[i]) s = {s, hex_byte(payload[i]), "_"};
	s = {s, hex_byte(trailer)};
	return s;
endfunction

// matrix takes priority when n*n equals n
function automatic void model_load(input int unsigned len, input byte_q_t payload);
	if (len == m_n * m_n) begin
		foreach (payload[i]) m_mat[i] = payload[i];
	end else if (len == m_n) begin
		foreach (payload[i]) m_vec[i] = payload[i];
	end
endfunction

function automatic void model_start();
	mxv_pkg::result_t sum;
	for (int r = 0; r < m_n; r++) begin
		sum = '0;
		for (int c = 0; c < m_n; c++) sum += m_mat[r * m_n + c] * m_vec[c]; // element (r,c)
		expected_q.push_back(sum);
	end
endfunction

`default_nettype wire

`endif

//--- verification/tb_mxv_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mxv_top;

	localparam int PERIOD = 40;
	localparam int ROUNDS = 6;
	localparam int FRAMES = 4 * ROUNDS + 16;
	localparam int FRAME_CYCLES = 840; // 64 byte load with widest gaps
	localparam int COMPUTE_CYCLES = 400;

	logic clk;
	logic rst;
	logic rcv;
	frame_pkg::char_t char;
	logic frame_ok;
	logic frame_error;
	logic busy;
	logic result_valid;
	logic result_ready;
	mxv_pkg::result_t result_data;

	int tests_run = 0;
	int tests_failed = 0;
	int ok_seen = 0;
	int err_seen = 0;
	int results_seen = 0;
	int result_errors = 0;
	int busy_rises = 0;
	logic busy_q = 1'b0;
	bit hold_ready = 1'b0; // keeps result_ready low

	`include "mxv_model.svh"

	mxv_top UUT (.clk(clk), .rst(rst), .rcv(rcv), .char(char), .frame_ok(frame_ok),
		.frame_error(frame_error), .busy(busy), .result_valid(result_valid),
		.result_ready(result_ready), .result_data(result_data));

	always #(PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		#1;
		result_ready = hold_ready ? 1'b0 : 1'($urandom_range(1)); // random back-pressure
	end

	// mid-cycle sampling, a transfer lands on the next rising edge
	always @(negedge clk) begin
		if (frame_ok) ok_seen++;
		if (frame_error) err_seen++;
		if (busy && !busy_q) busy_rises++;
		busy_q = busy;
		if (result_valid && result_ready) begin
			results_seen++;
			if (expected_q.size() == 0) begin
				result_errors++;
				$display("result %0d arrived with nothing outstanding", result_data);
			end else if (result_data !== expected_q[0]) begin
				result_errors++;
				$display("FAILED @%0t: result %0d, expected %0d", $time, result_data,
					expected_q[0]);
			end
			if (expected_q.size() != 0) void'(expected_q.pop_front());
		end
	end

	task automatic report(input string name, input bit fail);
		tests_run++;
		if (fail) begin
			tests_failed++;
		end
		$display("test %-24s %s", name, fail ? "failed" : "passed");
	endtask

	task automatic send_frame(input string s, input int max_gap);
		for (int i = 0; i < s.len(); i++) begin
			rcv = 1'b1;
			char = s[i];
			@(posedge clk);
			#1;
			rcv = 1'b0;
			repeat ($urandom_range(max_gap)) begin
				@(posedge clk);
				#1;
			end
		end
	endtask

	task automatic run_frame(input string name, input string frame, input bit good,
			input int max_gap);
		int ok0;
		int err0;
		int cycles;
		ok0 = ok_seen;
		err0 = err_seen;
		send_frame(frame, max_gap);
		cycles = 0;
		while (ok_seen + err_seen == ok0 + err0 && cycles < 20) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		repeat (3) @(posedge clk); // catch a stray second pulse
		#1;
		if (ok_seen - ok0 != int'(good) || err_seen - err0 != int'(!good)) begin
			$display("FAILED @%0t: %s gave %0d frame_ok and %0d frame_error", $time, name,
				ok_seen - ok0, err_seen - err0);
			report(name, 1'b1);
		end else begin
			report(name, 1'b0);
		end
	endtask

	task automatic do_size(input int unsigned val);
		byte_q_t p;
		p.push_back(8'(val));
		run_frame($sformatf("size %0d", val),
			build_frame(8'h01, frame_pkg::CMD_SIZE, p, frame_pkg::TOK_EF), 1'b1, 3);
		m_n = val;
	endtask

	task automatic do_load(input int unsigned len);
		byte_q_t p;
		repeat (len) p.push_back(8'($urandom));
		run_frame($sformatf("load %0d", len),
			build_frame(8'(len), frame_pkg::CMD_LOAD, p, frame_pkg::TOK_EF), 1'b1, 3);
		model_load(len, p);
	endtask

	// collide sends a SIZE frame while the engine is still running
	task automatic do_start(input bit collide);
		byte_q_t none;
		byte_q_t p;
		int res0;
		int rerr0;
		int rises0;
		int cycles;
		bit fail;
		res0 = results_seen;
		rerr0 = result_errors;
		rises0 = busy_rises;
		fail = 1'b0;
		model_start();
		run_frame("start", build_frame(8'h01, frame_pkg::CMD_START, none, frame_pkg::TOK_EF),
			1'b1, collide ? 0 : 3);
		if (collide) begin
			p.push_back(8'h03);
			run_frame("size while busy",
				build_frame(8'h01, frame_pkg::CMD_SIZE, p, frame_pkg::TOK_EF), 1'b0, 0);
		end
		cycles = 0;
		while ((results_seen - res0 < m_n || busy) && cycles < COMPUTE_CYCLES) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		repeat (4) @(posedge clk);
		#1;
		if (cycles >= COMPUTE_CYCLES) begin
			fail = 1'b1;
			$display("results for order %0d did not drain in time", m_n);
		end
		if (results_seen - res0 != m_n || busy_rises - rises0 != 1 || busy ||
				result_errors != rerr0 || expected_q.size() != 0) begin
			fail = 1'b1;
			$display("FAILED @%0t: order %0d gave %0d results, busy rose %0d times", $time,
				m_n, results_seen - res0, busy_rises - rises0);
		end
		report($sformatf("results order %0d", m_n), fail);
	endtask

	// second START finds the queue full of the first one's results
	task automatic do_backlog();
		byte_q_t none;
		int res0;
		int rerr0;
		int rises0;
		int cycles;
		bit fail;
		res0 = results_seen;
		rerr0 = result_errors;
		rises0 = busy_rises;
		fail = 1'b0;
		hold_ready = 1'b1;
		model_start();
		model_start();
		run_frame("start, output held",
			build_frame(8'h01, frame_pkg::CMD_START, none, frame_pkg::TOK_EF), 1'b1, 3);
		cycles = 0;
		while (busy && cycles < COMPUTE_CYCLES) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		run_frame("start on a full queue",
			build_frame(8'h01, frame_pkg::CMD_START, none, frame_pkg::TOK_EF), 1'b1, 3);
		repeat (2 * m_n * (m_n + 1)) begin // twice the free-running compute time
			@(posedge clk);
			#1;
		end
		if (!busy) begin
			fail = 1'b1;
			$display("engine finished with the result queue full and no reader");
		end
		hold_ready = 1'b0;
		cycles = 0;
		while ((results_seen - res0 < 2 * m_n || busy) && cycles < COMPUTE_CYCLES) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		repeat (4) @(posedge clk);
		#1;
		if (cycles >= COMPUTE_CYCLES) begin
			fail = 1'b1;
			$display("held results did not drain in time");
		end
		if (results_seen - res0 != 2 * m_n || busy_rises - rises0 != 2 || busy ||
				result_errors != rerr0 || expected_q.size() != 0) begin
			fail = 1'b1;
			$display("FAILED @%0t: held output gave %0d results, busy rose %0d times", $time,
				results_seen - res0, busy_rises - rises0);
		end
		report("held output backlog", fail);
	endtask

	initial begin
		byte_q_t none;
		void'($urandom(32'h92));
		clk = 1'b0;
		rst = 1'b0;
		rcv = 1'b0;
		char = '0;
		result_ready = 1'b0;
		model_reset();
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b1;
		for (int r = 0; r < ROUNDS; r++) begin
			do_size($urandom_range(8, 1));
			do_load(m_n * m_n);
			do_load(m_n);
			do_start(1'b0);
		end
		run_frame("bad character", "FE_01_0G_EF", 1'b0, 2);
		run_frame("missing separator", "FE01_01_05_EF", 1'b0, 2);
		run_frame("length zero", "FE_00_01_05_EF", 1'b0, 2);
		run_frame("command 04", "FE_01_04_EF", 1'b0, 2);
		run_frame("size 9", "FE_01_01_09_EF", 1'b0, 2);
		run_frame("wrong load length",
			build_frame(8'(m_n + 1), frame_pkg::CMD_LOAD, none, frame_pkg::TOK_EF), 1'b0, 2);
		run_frame("wrong trailer", "FE_01_01_05_EE", 1'b0, 2); // n stays as it was
		do_size($urandom_range(8, 1));
		do_size(8); // long enough compute to collide with
		do_load(64);
		do_load(8);
		do_start(1'b1);
		do_backlog();
		$display("tests %0d, passed %0d, failed %0d, result mismatches %0d", tests_run,
			tests_run - tests_failed, tests_failed, result_errors);
		if (tests_failed == 0 && result_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		#((FRAMES * FRAME_CYCLES + (ROUNDS + 4) * COMPUTE_CYCLES) * PERIOD);
		$display("watchdog expired before the tests finished");
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
source/mxv_pkg.sv
source/frame_pkg.sv
source/token_assembler.sv
source/frame_parser.sv
source/operand_store.sv
source/mxv_engine.sv
source/result_fifo.sv
source/mxv_top.sv
+incdir+verification
verification/tb_mxv_top.sv

//--- run_sim.sh
#!/bin/bash
# compile with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_mxv_top -f files.f \
	&& ./obj_dir/Vtb_mxv_top | tee sim.log \
	&& grep -qx "Everything OK" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
